//--- rtl/div_serial.sv
`timescale 1ns/10ps
`default_nettype none

module div_serial (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  exec_pkg::alu_op_t               op,
  input  logic [exec_pkg::XLEN-1:0]       dividend,
  input  logic [exec_pkg::XLEN-1:0]       divisor,
  output logic [exec_pkg::XLEN-1:0]       quotient_or_rem,
  output logic                            done
);

  import exec_pkg::*;

  typedef enum logic [1:0] {
    D_IDLE,
    D_RUN,
    D_FIX
  } div_state_t;

  div_state_t           state;
  logic [DIV_CNT_W-1:0] step;

  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] dvsr;
  logic            q_neg;
  logic            r_neg;
  logic            want_rem;

  logic            is_signed;
  logic [XLEN-1:0] abs_a;
  logic [XLEN-1:0] abs_b;
  logic [XLEN:0]   partial;
  logic [XLEN:0]   trial;
  logic            fits;

  assign is_signed = (op == OP_DIV) || (op == OP_REM);
  assign abs_a = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
  assign abs_b = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

  // Shift in next dividend bit, then try the subtract
  assign partial = {rem, quo[XLEN-1]};
  assign trial   = partial - {1'b0, dvsr};
  assign fits    = partial >= {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= D_IDLE;
      step  <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        D_IDLE: begin
          if (start) begin
            state <= D_RUN;
            step  <= '0;
          end
        end
        D_RUN: begin
          step <= step + 1'b1;
          if (&step) begin
            state <= D_FIX;
          end
        end
        D_FIX: begin
          state <= D_IDLE;
          done  <= 1'b1;   // Result register valid next cycle
        end
        default: begin
          state <= D_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo      <= abs_a;
      rem      <= '0;
      dvsr     <= abs_b;
      // Zero divisor keeps the all-ones quotient unsigned
      q_neg    <= is_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]) && (divisor != '0);
      r_neg    <= is_signed && dividend[XLEN-1];
      want_rem <= (op == OP_REM) || (op == OP_REMU);
    end else if (state == D_RUN) begin
      rem <= fits ? trial[XLEN-1:0] : partial[XLEN-1:0];
      quo <= {quo[XLEN-2:0], fits};
    end else if (state == D_FIX) begin
      if (want_rem) begin
        quotient_or_rem <= r_neg ? -rem : rem;
      end else begin
        quotient_or_rem <= q_neg ? -quo : quo;
      end
    end
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    start |-> state == D_IDLE)
    else $error("divider start while busy");

endmodule

`default_nettype wire

//--- rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int XLEN      = 32;
  localparam int MUL_LAT   = 3;                     // Multiplier pipeline depth
  localparam int MUL_CNT_W = $clog2(MUL_LAT + 1);
  localparam int DIV_CNT_W = $clog2(XLEN);          // One count per quotient bit

  typedef enum logic [4:0] {
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_EQ,
    OP_PASS,
    OP_MUL,
    OP_MULH,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } alu_op_t;

  typedef struct packed {
    alu_op_t         op;
    logic [XLEN-1:0] left;
    logic [XLEN-1:0] right;
  } exec_req_t;

  // Which unit serves an operation
  typedef enum logic [1:0] {
    CLASS_SINGLE,
    CLASS_MUL,
    CLASS_DIV
  } op_class_t;

  function automatic op_class_t op_class(alu_op_t op);
    case (op)
      OP_MUL, OP_MULH, OP_MULHU: begin
        return CLASS_MUL;
      end
      OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
        return CLASS_DIV;
      end
      default: begin
        return CLASS_SINGLE;
      end
    endcase
  endfunction

endpackage

`default_nettype wire

//--- rtl/exec_stall.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stall (
  input  logic                    clk,
  input  logic                    rst,
  input  exec_pkg::alu_op_t       op,
  input  logic                    div_done,
  output logic                    div_start,
  output logic                    stall
);

  import exec_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_MUL_CNT,
    S_DIV_WAIT
  } state_t;

  state_t               state;
  logic [MUL_CNT_W-1:0] mul_cnt;
  op_class_t            cls;
  logic                 mul_last;

  assign cls      = op_class(op);
  assign mul_last = mul_cnt == MUL_CNT_W'(MUL_LAT);

  always_comb begin
    div_start = 1'b0;
    stall     = 1'b0;
    case (state)
      S_IDLE: begin
        stall     = cls != CLASS_SINGLE;   // First cycle of a multi-cycle op
        div_start = cls == CLASS_DIV;
      end
      S_MUL_CNT: begin
        stall = !mul_last;
      end
      S_DIV_WAIT: begin
        stall = !div_done;
      end
      default: begin
        stall = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      mul_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cls == CLASS_MUL) begin
            state   <= S_MUL_CNT;
            mul_cnt <= MUL_CNT_W'(1);
          end else if (cls == CLASS_DIV) begin
            state <= S_DIV_WAIT;
          end
        end
        S_MUL_CNT: begin
          if (mul_last) begin
            state   <= S_IDLE;
            mul_cnt <= '0;
          end else begin
            mul_cnt <= mul_cnt + 1'b1;
          end
        end
        S_DIV_WAIT: begin
          if (div_done) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
    div_done |-> state == S_DIV_WAIT)
    else $error("divider done outside of wait state");

  a_stall_bound: assert property (@(posedge clk) disable iff (rst)
    $rose(stall) |-> ##[1:40] !stall)
    else $error("stall held longer than 40 cycles");

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  exec_pkg::exec_req_t             req,
  output logic [exec_pkg::XLEN-1:0]       result,
  output logic                            stall
);

  import exec_pkg::*;

  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] mul_res;
  logic [XLEN-1:0] div_res;
  logic            div_start;
  logic            div_done;

  int_alu u_alu (
    .req     (req),
    .alu_res (alu_res)
  );

  mul_pipe u_mul (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .mul_res (mul_res)
  );

  div_serial u_div (
    .clk             (clk),
    .rst             (rst),
    .start           (div_start),
    .op              (req.op),
    .dividend        (req.left),
    .divisor         (req.right),
    .quotient_or_rem (div_res),
    .done            (div_done)
  );

  exec_stall u_stall (
    .clk       (clk),
    .rst       (rst),
    .op        (req.op),
    .div_done  (div_done),
    .div_start (div_start),
    .stall     (stall)
  );

  // Only meaningful once stall drops
  always_comb begin
    case (op_class(req.op))
      CLASS_MUL: begin
        result = mul_res;
      end
      CLASS_DIV: begin
        result = div_res;
      end
      default: begin
        result = alu_res;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu (
  input  exec_pkg::exec_req_t             req,
  output logic [exec_pkg::XLEN-1:0]       alu_res
);

  import exec_pkg::*;

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic            equal;

  assign sum   = req.left + req.right;
  assign diff  = req.left - req.right;
  assign shamt = req.right[4:0];   // Upper bits of the shift amount ignored

  assign lt_signed   = $signed(req.left) < $signed(req.right);
  assign lt_unsigned = req.left < req.right;
  assign equal       = req.left == req.right;

  always_comb begin
    case (req.op)
      OP_AND: begin
        alu_res = req.left & req.right;
      end
      OP_OR: begin
        alu_res = req.left | req.right;
      end
      OP_XOR: begin
        alu_res = req.left ^ req.right;
      end
      OP_ADD: begin
        alu_res = sum;
      end
      OP_SUB: begin
        alu_res = diff;
      end
      OP_SLL: begin
        alu_res = req.left << shamt;
      end
      OP_SRL: begin
        alu_res = req.left >> shamt;
      end
      OP_SRA: begin
        alu_res = $signed(req.left) >>> shamt;
      end
      OP_SLT: begin
        alu_res = {{(XLEN-1){1'b0}}, lt_signed};
      end
      OP_SLTU: begin
        alu_res = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      OP_EQ: begin
        alu_res = {{(XLEN-1){1'b0}}, equal};
      end
      OP_PASS: begin
        alu_res = req.left;
      end
      default: begin
        alu_res = sum;   // Multi-cycle ops land here too, result muxed away at top
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/mul_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module mul_pipe (
  input  logic                            clk,
  input  logic                            rst,
  input  exec_pkg::exec_req_t             req,
  output logic [exec_pkg::XLEN-1:0]       mul_res
);

  import exec_pkg::*;

  logic                    is_mulh;
  logic                    want_hi;
  logic signed [XLEN:0]    a_s1;      // 33-bit operands
  logic signed [XLEN:0]    b_s1;
  logic signed [2*XLEN+1:0] prod_s2;
  logic [MUL_LAT-2:0]      hi_sel;    // Half select travels beside the data

  assign is_mulh = req.op == OP_MULH;
  assign want_hi = is_mulh || (req.op == OP_MULHU);

  // Free running, a new pair may enter every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      a_s1    <= '0;
      b_s1    <= '0;
      prod_s2 <= '0;
      hi_sel  <= '0;
      mul_res <= '0;
    end else begin
      // Sign extend only for MULH, MUL low half is the same either way
      a_s1    <= {is_mulh & req.left[XLEN-1], req.left};
      b_s1    <= {is_mulh & req.right[XLEN-1], req.right};
      prod_s2 <= a_s1 * b_s1;
      hi_sel  <= {hi_sel[MUL_LAT-3:0], want_hi};
      if (hi_sel[MUL_LAT-2]) begin
        mul_res <= prod_s2[2*XLEN-1:XLEN];
      end else begin
        mul_res <= prod_s2[XLEN-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module exec_tb -o exec_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/exec_tb_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+verification
rtl/exec_pkg.sv
rtl/int_alu.sv
rtl/mul_pipe.sv
rtl/div_serial.sv
rtl/exec_stall.sv
rtl/exec_unit.sv
verification/exec_tb.sv

//--- verification/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Reference model, included inside exec_tb after the package import

function automatic op_class_t ref_class(input alu_op_t op);
  if (op inside {OP_MUL, OP_MULH, OP_MULHU}) begin
    return CLASS_MUL;
  end else if (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) begin
    return CLASS_DIV;
  end
  return CLASS_SINGLE;
endfunction

function automatic logic [XLEN-1:0] ref_result(input exec_req_t r);
  logic signed [XLEN-1:0] a;
  logic signed [XLEN-1:0] b;
  logic signed [XLEN-1:0] quo_s;
  logic signed [XLEN-1:0] rem_s;
  logic [2*XLEN-1:0]      wide_s;
  logic [2*XLEN-1:0]      wide_u;
  logic [4:0]             sh;
  logic                   ovf;
  logic                   by_zero;
  a       = r.left;
  b       = r.right;
  sh      = r.right[4:0];   // Shift amount wraps at 32
  wide_u  = {{XLEN{1'b0}}, r.left} * {{XLEN{1'b0}}, r.right};
  wide_s  = {{XLEN{r.left[XLEN-1]}}, r.left} * {{XLEN{r.right[XLEN-1]}}, r.right};
  ovf     = (r.left == 32'h8000_0000) && (r.right == 32'hffff_ffff);
  by_zero = r.right == '0;
  quo_s   = '0;
  rem_s   = '0;
  if (!by_zero && !ovf) begin
    quo_s = a / b;   // Signed quotient and remainder
    rem_s = a % b;
  end
  case (r.op)
    OP_AND:   return r.left & r.right;
    OP_OR:    return r.left | r.right;
    OP_XOR:   return r.left ^ r.right;
    OP_ADD:   return r.left + r.right;
    OP_SUB:   return r.left - r.right;
    OP_SLL:   return r.left << sh;
    OP_SRL:   return r.left >> sh;
    OP_SRA:   return a >>> sh;
    OP_SLT:   return (a < b) ? 32'd1 : 32'd0;
    OP_SLTU:  return (r.left < r.right) ? 32'd1 : 32'd0;
    OP_EQ:    return (r.left == r.right) ? 32'd1 : 32'd0;
    OP_PASS:  return r.left;
    OP_MUL:   return wide_u[XLEN-1:0];
    OP_MULH:  return wide_s[2*XLEN-1:XLEN];
    OP_MULHU: return wide_u[2*XLEN-1:XLEN];
    // RISC-V divide rules: x/0 is all ones, x%0 is x, MIN/-1 is MIN rem 0
    OP_DIV:   return by_zero ? '1 : (ovf ? r.left : quo_s);
    OP_DIVU:  return by_zero ? '1 : r.left / r.right;
    OP_REM:   return by_zero ? r.left : (ovf ? '0 : rem_s);
    OP_REMU:  return by_zero ? r.left : r.left % r.right;
    default:  return r.left + r.right;
  endcase
endfunction

`endif

//--- verification/exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_tb;

  import exec_pkg::*;

  `include "exec_ref.svh"

  localparam int N_RANDOM       = 2000;
  localparam int N_DIRECTED     = 37;
  localparam int MUL_STALL      = 3;
  localparam int MAX_OP_CYCLES  = 40;     // Divide bound, well above 35
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * MAX_OP_CYCLES + RESET_CYCLES + 100;

  logic            clk;
  logic            rst;
  exec_req_t       req;
  logic [XLEN-1:0] result;
  logic            stall;

  logic [31:0] rng_state = 32'h42af;
  int          cycle_count = 0;

  exec_unit DUT (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .result (result),
    .stall  (stall)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, the test sequence never finished",
                          cycle_count));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual));
    end
  endtask

  task automatic check_stall(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s stall expected %0b actual %0b", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic exec_req_t make_req(input alu_op_t op, input logic [31:0] left,
                                         input logic [31:0] right);
    exec_req_t r;
    r.op    = op;
    r.left  = left;
    r.right = right;
    return r;
  endfunction

  task automatic make_random_req(output exec_req_t r);
    logic [31:0] bias;
    r.op    = alu_op_t'(5'(draw_random() % 32'd19));
    r.left  = draw_random();
    r.right = draw_random();
    bias    = draw_random();
    if (bias[2:0] == 3'd0 && ref_class(r.op) == CLASS_DIV) begin
      r.right = '0;
    end else if (bias[5:3] == 3'd0) begin
      r.left  = 32'h8000_0000;   // Signed overflow pair
      r.right = 32'hffff_ffff;
    end else if (bias[8:6] == 3'd0) begin
      r.right = r.left;
    end else if (bias[11:9] == 3'd0) begin
      r.right = {28'd0, bias[15:12]};   // Small divisors and shift amounts
    end
  endtask

  // One instruction: drive, follow stall for its class, then check the result
  task automatic run_op(input string name, input exec_req_t r);
    string           tag;
    op_class_t       cls;
    logic [XLEN-1:0] expected;
    int              waited;
    int              i;
    tag      = $sformatf("%s %s", name, r.op.name());
    cls      = ref_class(r.op);
    expected = ref_result(r);
    waited   = 0;
    @(posedge clk);
    req <= r;
    @(negedge clk);
    if (cls == CLASS_MUL) begin
      for (i = 0; i < MUL_STALL; i++) begin
        check_stall(tag, 1'b1, stall);
        @(negedge clk);
      end
    end else if (cls == CLASS_DIV) begin
      check_stall(tag, 1'b1, stall);
      while (stall) begin
        @(negedge clk);
        waited++;
        if (waited > MAX_OP_CYCLES) begin
          abort_run($sformatf("Stall stayed high past %0d cycles on %s", MAX_OP_CYCLES, tag));
        end
      end
    end
    check_stall(tag, 1'b0, stall);
    check_result(tag, expected, result);
  endtask

  initial begin
    exec_req_t r;
    int        i;
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_stall("after_reset", 1'b0, stall);

    // Every single-cycle kind, shift amount 0x124 keeps only 4
    for (i = 0; i <= int'(OP_PASS); i++) begin
      run_op("single", make_req(alu_op_t'(5'(i)), 32'h8000_00f3, 32'h0000_0124));
    end
    run_op("mul", make_req(OP_MUL, 32'hffff_fff9, 32'h0001_2345));
    run_op("mul", make_req(OP_MULH, 32'hffff_fff9, 32'h8000_0001));
    run_op("mul", make_req(OP_MULHU, 32'hffff_fff9, 32'h8000_0001));
    run_op("div", make_req(OP_DIV, 32'hffff_ff9c, 32'd7));   // -100 / 7
    run_op("div", make_req(OP_DIVU, 32'hffff_ff9c, 32'd7));
    run_op("div", make_req(OP_REM, 32'hffff_ff9c, 32'd7));
    run_op("div", make_req(OP_REMU, 32'd1000, 32'hffff_fff9));
    for (i = int'(OP_DIV); i <= int'(OP_REMU); i++) begin
      run_op("div_by_zero", make_req(alu_op_t'(5'(i)), 32'hdead_beef, 32'd0));
    end
    for (i = int'(OP_DIV); i <= int'(OP_REMU); i++) begin
      run_op("min_by_minus_one", make_req(alu_op_t'(5'(i)), 32'h8000_0000, 32'hffff_ffff));
    end
    run_op("wide_shift", make_req(OP_SLL, 32'h0000_0f0f, 32'd33));
    run_op("wide_shift", make_req(OP_SRL, 32'hf0f0_0000, 32'd63));
    run_op("wide_shift", make_req(OP_SRA, 32'h8000_0000, 32'hffff_ffe1));

    // Mixed stream, divide then multiply, and one multiply twice
    run_op("mixed", make_req(OP_DIV, 32'd12345, 32'hffff_fffd));
    run_op("mixed", make_req(OP_MUL, 32'd777, 32'd999));
    run_op("mixed", make_req(OP_MUL, 32'd777, 32'd999));
    run_op("mixed", make_req(OP_ADD, 32'hffff_ffff, 32'd1));
    run_op("mixed", make_req(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff));
    run_op("mixed", make_req(OP_REM, 32'h8000_0001, 32'd10));
    run_op("mixed", make_req(OP_SLT, 32'h8000_0000, 32'd1));

    for (i = 0; i < N_RANDOM; i++) begin
      make_random_req(r);
      run_op($sformatf("random %0d", i), r);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
